// File: Makefile
TOP = tb_mister_top

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -f vlog.f --top-module mister_top

clean:
	rm -rf obj_dir

// File: dwnld_if.sv
// One ROM byte in flight at a time; PROG_AW must leave room for the dropped byte-lane bit
`default_nettype none
`timescale 1ns/1ps

interface dwnld_if #(
    parameter int PROG_AW = 23
);

    // Router to writer, valid is a single-cycle pulse
    logic                            valid;
    logic [mister_pkg::HPS_AW-1:0]   addr;
    mister_pkg::byte_t               data;

    // Writer to router, pulses when the SDRAM takes the byte
    logic                            done;

    // Word address is the byte address without bit 0
    if (PROG_AW > mister_pkg::HPS_AW - 1) begin : g_aw_check
        $error("PROG_AW does not fit in the host byte address");
    end

    modport router (
        output valid,
        output addr,
        output data,
        input  done
    );

    modport writer (
        input  valid,
        input  addr,
        input  data,
        output done
    );

endinterface

`default_nettype wire

// File: dwnld_router.sv
// Host must keep hps_wr low while hps_wait is high; only DIP addresses 0 to 3 are stored
`default_nettype none
`timescale 1ns/1ps

module dwnld_router (
    input  logic                            clk_sys,
    input  logic                            rst,

    // Host download stream
    input  logic                            hps_download,
    input  logic [7:0]                      hps_index,
    input  logic                            hps_wr,
    input  logic [mister_pkg::HPS_AW-1:0]   hps_addr,
    input  mister_pkg::byte_t               hps_dout,
    output logic                            hps_wait,

    // ROM side
    output logic                            downloading,
    output logic                            ioctl_rom_wr,
    output logic [mister_pkg::HPS_AW-1:0]   ioctl_addr,
    output mister_pkg::byte_t               ioctl_dout,

    // Configuration
    output logic [31:0]                     dipsw,

    dwnld_if.router                         dl
);

    mister_pkg::dwnld_kind_t kind;
    logic                    rom_accept;
    logic                    dip_accept;

    // Index decode
    always_comb begin
        case (hps_index)
            mister_pkg::ROM_INDEX: kind = mister_pkg::KIND_ROM;
            mister_pkg::DIP_INDEX: kind = mister_pkg::KIND_DIP;
            default:               kind = mister_pkg::KIND_NONE;
        endcase
    end

    // A new ROM byte is taken only when the previous one has been written
    assign rom_accept = hps_wr && !hps_wait && (kind == mister_pkg::KIND_ROM);

    // DIP bytes go straight to the register, no wait cycle
    assign dip_accept = hps_wr && (kind == mister_pkg::KIND_DIP) &&
                        (hps_addr[mister_pkg::HPS_AW-1:2] == '0);

    // Control state
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            downloading  <= 1'b0;
            ioctl_rom_wr <= 1'b0;
            hps_wait     <= 1'b0;
        end else begin
            downloading  <= hps_download && (kind == mister_pkg::KIND_ROM);
            ioctl_rom_wr <= rom_accept;
            if (rom_accept) begin
                hps_wait <= 1'b1;
            end else if (dl.done) begin
                // Released one cycle after the writer finishes
                hps_wait <= 1'b0;
            end
        end
    end

    // Byte payload, valid when ioctl_rom_wr is high
    always_ff @(posedge clk_sys) begin
        if (rom_accept) begin
            ioctl_addr <= hps_addr;
            ioctl_dout <= hps_dout;
        end
    end

    // DIP switch lanes, one byte per address
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dipsw <= '0;
        end else if (dip_accept) begin
            dipsw[{hps_addr[1:0], 3'b000} +: 8] <= hps_dout;
        end
    end

    // The writer sees the same pulse and payload as the ioctl outputs
    assign dl.valid = ioctl_rom_wr;
    assign dl.addr  = ioctl_addr;
    assign dl.data  = ioctl_dout;

    // Host protocol: no write while the previous ROM byte is pending
    a_no_wr_in_wait: assert property (
        @(posedge clk_sys) disable iff (rst)
        hps_wait |-> !hps_wr
    ) else $error("hps_wr raised while hps_wait is high");

endmodule

`default_nettype wire

// File: mister_pkg.sv
// Shared widths and indexes; HIST_DEPTH must equal 2**OFFSET_W so every offset selects a tap
`default_nettype none

package mister_pkg;

    // One byte of the host download stream
    typedef logic [7:0] byte_t;

    // Host byte address width
    localparam int HPS_AW = 27;

    // Resync offsets, one nibble each from status[31:24]
    localparam int OFFSET_W   = 4;
    localparam int HIST_DEPTH = 16;

    // Download indexes sent by the host
    localparam logic [7:0] ROM_INDEX = 8'd0;
    localparam logic [7:0] DIP_INDEX = 8'd254;

    // What the current index selects
    typedef enum logic [1:0] {
        KIND_ROM,
        KIND_DIP,
        KIND_NONE
    } dwnld_kind_t;

    // SDRAM programming writer
    typedef enum logic {
        WR_IDLE,
        // Write presented, waiting for prog_rdy
        WR_HOLD
    } writer_state_t;

endpackage

`default_nettype wire

// File: mister_top.sv
// Single clock domain; status[31:28] is the line delay and status[27:24] the pixel delay
`default_nettype none
`timescale 1ns/1ps

module mister_top #(
    parameter int PROG_AW = 23
) (
    input  logic                            clk_sys,
    input  logic                            rst,

    // Host download stream
    input  logic                            hps_download,
    input  logic [7:0]                      hps_index,
    input  logic                            hps_wr,
    input  logic [mister_pkg::HPS_AW-1:0]   hps_addr,
    input  mister_pkg::byte_t               hps_dout,
    output logic                            hps_wait,

    // ROM programming
    output logic                            downloading,
    output logic                            ioctl_rom_wr,
    output logic [mister_pkg::HPS_AW-1:0]   ioctl_addr,
    output mister_pkg::byte_t               ioctl_dout,
    output logic [PROG_AW-1:0]              prog_addr,
    output logic [15:0]                     prog_data,
    output logic [1:0]                      prog_mask,
    output logic                            prog_we,
    input  logic                            prog_rdy,

    // Configuration
    input  logic [31:0]                     status,
    output logic [31:0]                     dipsw,

    // Video sync
    input  logic                            pxl_cen,
    input  logic                            hs,
    input  logic                            vs,
    output logic                            hs_resync,
    output logic                            vs_resync
);

    logic [mister_pkg::OFFSET_W-1:0] hoffset;
    logic [mister_pkg::OFFSET_W-1:0] voffset;

    assign {voffset, hoffset} = status[31:24];

    // Router to writer link
    dwnld_if #(
        .PROG_AW        ( PROG_AW       )
    ) u_dl ();

    dwnld_router u_router (
        .clk_sys        ( clk_sys       ),
        .rst            ( rst           ),
        .hps_download   ( hps_download  ),
        .hps_index      ( hps_index     ),
        .hps_wr         ( hps_wr        ),
        .hps_addr       ( hps_addr      ),
        .hps_dout       ( hps_dout      ),
        .hps_wait       ( hps_wait      ),
        .downloading    ( downloading   ),
        .ioctl_rom_wr   ( ioctl_rom_wr  ),
        .ioctl_addr     ( ioctl_addr    ),
        .ioctl_dout     ( ioctl_dout    ),
        .dipsw          ( dipsw         ),
        .dl             ( u_dl          )
    );

    prog_writer #(
        .PROG_AW        ( PROG_AW       )
    ) u_writer (
        .clk_sys        ( clk_sys       ),
        .rst            ( rst           ),
        .dl             ( u_dl          ),
        .prog_rdy       ( prog_rdy      ),
        .prog_addr      ( prog_addr     ),
        .prog_data      ( prog_data     ),
        .prog_mask      ( prog_mask     ),
        .prog_we        ( prog_we       )
    );

    sync_resync u_resync (
        .clk_sys        ( clk_sys       ),
        .rst            ( rst           ),
        .pxl_cen        ( pxl_cen       ),
        .hs             ( hs            ),
        .vs             ( vs            ),
        .hoffset        ( hoffset       ),
        .voffset        ( voffset       ),
        .hs_out         ( hs_resync     ),
        .vs_out         ( vs_resync     )
    );

endmodule

`default_nettype wire

// File: prog_writer.sv
// Single outstanding write; prog_rdy is sampled only while prog_we is high
`default_nettype none
`timescale 1ns/1ps

module prog_writer #(
    parameter int PROG_AW = 23
) (
    input  logic                clk_sys,
    input  logic                rst,

    dwnld_if.writer             dl,

    // SDRAM programming port
    input  logic                prog_rdy,
    output logic [PROG_AW-1:0]  prog_addr,
    output logic [15:0]         prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we
);

    mister_pkg::writer_state_t state;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            state <= mister_pkg::WR_IDLE;
        end else begin
            case (state)
                mister_pkg::WR_IDLE: begin
                    if (dl.valid) begin
                        state <= mister_pkg::WR_HOLD;
                    end
                end
                mister_pkg::WR_HOLD: begin
                    if (prog_rdy) begin
                        state <= mister_pkg::WR_IDLE;
                    end
                end
                default: state <= mister_pkg::WR_IDLE;
            endcase
        end
    end

    // Word write captured once and held until the SDRAM accepts it
    always_ff @(posedge clk_sys) begin
        if (state == mister_pkg::WR_IDLE && dl.valid) begin
            prog_addr <= dl.addr[PROG_AW:1];
            // Same byte on both lanes so the mask picks the one written
            prog_data <= {dl.data, dl.data};
            // Active low mask with odd bytes in the upper lane
            prog_mask <= dl.addr[0] ? 2'b01 : 2'b10;
        end
    end

    assign prog_we = (state == mister_pkg::WR_HOLD);

    // Lets the router release hps_wait
    assign dl.done = (state == mister_pkg::WR_HOLD) && prog_rdy;

    // The SDRAM side may stall for any number of cycles
    a_hold_stable: assert property (
        @(posedge clk_sys) disable iff (rst)
        (prog_we && !prog_rdy) |=> $stable({prog_addr, prog_data, prog_mask})
    ) else $error("programming write changed before prog_rdy");

endmodule

`default_nettype wire

// File: sync_resync.sv
// Offsets are delays of 0 to 15 ticks only; a line starts on each rising hs at a pixel tick
`default_nettype none
`timescale 1ns/1ps

module sync_resync (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  logic                            pxl_cen,
    input  logic                            hs,
    input  logic                            vs,
    input  logic [mister_pkg::OFFSET_W-1:0] hoffset,
    input  logic [mister_pkg::OFFSET_W-1:0] voffset,
    output logic                            hs_out,
    output logic                            vs_out
);

    // Entry 0 holds the newest sample
    logic [mister_pkg::HIST_DEPTH-1:0] hs_hist;
    logic [mister_pkg::HIST_DEPTH-1:0] vs_hist;

    // hs as seen at the previous pixel tick
    logic hs_last;
    logic line_tick;

    assign line_tick = pxl_cen && hs && !hs_last;

    // Pixel history
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hs_hist <= '0;
            hs_last <= 1'b0;
        end else if (pxl_cen) begin
            hs_hist <= {hs_hist[mister_pkg::HIST_DEPTH-2:0], hs};
            hs_last <= hs;
        end
    end

    // Line history, one entry per hs rising edge
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vs_hist <= '0;
        end else if (line_tick) begin
            vs_hist <= {vs_hist[mister_pkg::HIST_DEPTH-2:0], vs};
        end
    end

    // Tap selection
    assign hs_out = hs_hist[hoffset];
    assign vs_out = vs_hist[voffset];

    // vs only moves on line boundaries unless the offset itself changes
    a_vs_on_line: assert property (
        @(posedge clk_sys) disable iff (rst)
        (!$past(line_tick) && $stable(voffset)) |-> $stable(vs_out)
    ) else $error("vs_out changed without a line tick");

endmodule

`default_nettype wire

// File: tb_mister_top.sv
// Bench for mister_top at PROG_AW 23; the host model never writes while hps_wait is high
`default_nettype none
`timescale 1ns/1ps

module tb_mister_top;

    localparam int PROG_AW      = 23;
    localparam int AW           = mister_pkg::HPS_AW;
    localparam int ROM_BYTES    = 64;
    localparam int CYCLE_LIMIT  = 20000;
    // 12 lines of 32 pixel ticks, one tick every other cycle
    localparam int FRAME_CYCLES = 768;

    logic               clk_sys;
    logic               rst;
    logic               hps_download;
    logic [7:0]         hps_index;
    logic               hps_wr;
    logic [AW-1:0]      hps_addr;
    mister_pkg::byte_t  hps_dout;
    logic               hps_wait;
    logic               downloading;
    logic               ioctl_rom_wr;
    logic [AW-1:0]      ioctl_addr;
    mister_pkg::byte_t  ioctl_dout;
    logic [PROG_AW-1:0] prog_addr;
    logic [15:0]        prog_data;
    logic [1:0]         prog_mask;
    logic               prog_we;
    logic               prog_rdy;
    logic [31:0]        status;
    logic [31:0]        dipsw;
    logic               pxl_cen;
    logic               hs;
    logic               vs;
    logic               hs_resync;
    logic               vs_resync;

    logic [31:0]        rand_state;
    logic               quiet_phase;
    int                 cycle_count = 0;
    int                 h_cnt;
    int                 v_cnt;
    mister_pkg::byte_t  dip_bytes [4];

    // Reference models
    logic [AW+7:0]      sent_q [$];
    int                 pending_cnt;
    int                 sent_count;
    int                 rise_count;
    logic               we_last;
    logic [AW-1:0]      acc_addr;
    mister_pkg::byte_t  acc_data;
    logic [PROG_AW-1:0] exp_word;
    mister_pkg::byte_t  exp_byte;
    logic [1:0]         exp_mask;
    logic               dl_model;
    logic [31:0]        dip_model;
    logic [15:0]        hs_model;
    logic [15:0]        vs_model;
    logic               hs_tick_last;
    logic               hs_expect;
    logic               vs_expect;
    logic               rom_accept_in;

    mister_top #(.PROG_AW(PROG_AW)) DUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic send_rom_byte(input logic [AW-1:0] addr, input mister_pkg::byte_t data);
        logic [31:0] r;
        int          delay;
        r = lcg_next();
        delay = int'(r % 32'd6);
        hps_wr = 1'b1;
        hps_addr = addr;
        hps_dout = data;
        next_cycle();
        hps_wr = 1'b0;
        while (!prog_we) next_cycle();
        // SDRAM stall
        repeat (delay) next_cycle();
        prog_rdy = 1'b1;
        next_cycle();
        prog_rdy = 1'b0;
        while (hps_wait) next_cycle();
    endtask

    task automatic write_strobe(input logic [AW-1:0] addr, input mister_pkg::byte_t data);
        hps_wr = 1'b1;
        hps_addr = addr;
        hps_dout = data;
        next_cycle();
        hps_wr = 1'b0;
        next_cycle();
    endtask

    // Video timing, 32 ticks per line with 4 of hs, 3 of 12 lines with vs
    initial begin : sync_gen
        h_cnt = 0;
        v_cnt = 0;
        forever begin
            next_cycle();
            pxl_cen = ~pxl_cen;
            if (pxl_cen) begin
                hs = (h_cnt < 4);
                vs = (v_cnt < 3);
                if (h_cnt == 31) begin
                    h_cnt = 0;
                    v_cnt = (v_cnt == 11) ? 0 : v_cnt + 1;
                end else begin
                    h_cnt = h_cnt + 1;
                end
            end
        end
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout, run did not finish in %0d cycles", CYCLE_LIMIT));
        end
    end

    assign rom_accept_in = hps_wr && !hps_wait && (hps_index == mister_pkg::ROM_INDEX);

    // Download side model, in-order queue of accepted ROM bytes
    always @(posedge clk_sys) begin : rom_monitor
        logic [AW-1:0]     head_addr;
        mister_pkg::byte_t head_byte;
        if (rst) begin
            sent_q.delete();
            pending_cnt <= 0;
            sent_count <= 0;
            rise_count <= 0;
            we_last <= 1'b0;
            dl_model <= 1'b0;
            dip_model <= '0;
        end else begin
            dl_model <= hps_download && (hps_index == mister_pkg::ROM_INDEX);
            if (prog_we && prog_rdy && sent_q.size() > 0) begin
                void'(sent_q.pop_front());
            end
            if (rom_accept_in) begin
                sent_q.push_back({hps_addr, hps_dout});
                sent_count <= sent_count + 1;
                acc_addr <= hps_addr;
                acc_data <= hps_dout;
            end
            if (hps_wr && hps_index == mister_pkg::DIP_INDEX && hps_addr < AW'(4)) begin
                dip_model[8 * int'(hps_addr[1:0]) +: 8] <= hps_dout;
            end
            if (prog_we && !we_last) begin
                rise_count <= rise_count + 1;
            end
            we_last <= prog_we;
            pending_cnt <= sent_q.size();
            if (sent_q.size() > 0) begin
                {head_addr, head_byte} = sent_q[0];
                exp_word <= PROG_AW'(head_addr >> 1);
                exp_byte <= head_byte;
                exp_mask <= ~(2'b01 << head_addr[0]);
            end
        end
    end

    // Sync histories, newest sample at index 0
    always @(posedge clk_sys) begin : sync_model
        if (rst) begin
            hs_model <= '0;
            vs_model <= '0;
            hs_tick_last <= 1'b0;
        end else if (pxl_cen) begin
            for (int i = mister_pkg::HIST_DEPTH - 1; i > 0; i--) begin
                hs_model[i] <= hs_model[i-1];
            end
            hs_model[0] <= hs;
            hs_tick_last <= hs;
            if (hs && !hs_tick_last) begin
                vs_model <= {vs_model[14:0], vs};
            end
        end
    end

    assign hs_expect = hs_model[status[27:24]];
    assign vs_expect = vs_model[status[31:28]];

    a_reset: assert property (@(posedge clk_sys) (!rst && $past(rst)) |->
        ({hps_wait, downloading, ioctl_rom_wr, prog_we, hs_resync, vs_resync, dipsw} == '0))
        else abort_run($sformatf("Fail reset: expected 0, actual %h", $sampled({hps_wait,
            downloading, ioctl_rom_wr, prog_we, hs_resync, vs_resync, dipsw})));
    a_downloading: assert property (@(posedge clk_sys) disable iff (rst) downloading == dl_model)
        else abort_run($sformatf("Fail downloading: expected %b, actual %b",
            $sampled(dl_model), $sampled(downloading)));
    a_rom_accept: assert property (@(posedge clk_sys) disable iff (rst)
        rom_accept_in |=> (ioctl_rom_wr && hps_wait))
        else abort_run($sformatf("Fail rom_accept: expected 11, actual %b%b",
            $sampled(ioctl_rom_wr), $sampled(hps_wait)));
    a_ioctl: assert property (@(posedge clk_sys) disable iff (rst)
        ioctl_rom_wr |-> ({ioctl_addr, ioctl_dout} == {acc_addr, acc_data}))
        else abort_run($sformatf("Fail ioctl: expected %h, actual %h",
            $sampled({acc_addr, acc_data}), $sampled({ioctl_addr, ioctl_dout})));
    a_in_flight: assert property (@(posedge clk_sys) disable iff (rst) prog_we |-> pending_cnt == 1)
        else abort_run($sformatf("Fail in_flight: expected 1, actual %0d", $sampled(pending_cnt)));
    a_rom_write: assert property (@(posedge clk_sys) disable iff (rst)
        prog_we |-> ({prog_addr, prog_data, prog_mask} == {exp_word, exp_byte, exp_byte, exp_mask}))
        else abort_run($sformatf("Fail rom_write: expected %h, actual %h",
            $sampled({exp_word, exp_byte, exp_byte, exp_mask}),
            $sampled({prog_addr, prog_data, prog_mask})));
    a_wait_held: assert property (@(posedge clk_sys) disable iff (rst) prog_we |-> hps_wait)
        else abort_run("hps_wait went low while a ROM write was still held");
    a_write_ends: assert property (@(posedge clk_sys) disable iff (rst)
        (prog_we && prog_rdy) |=> (!prog_we && !hps_wait))
        else abort_run("prog_we or hps_wait stayed high after prog_rdy");
    a_quiet: assert property (@(posedge clk_sys) disable iff (rst)
        quiet_phase |-> !(prog_we || ioctl_rom_wr || downloading || hps_wait))
        else abort_run("ROM activity seen during a DIP or ignored download");
    a_dipsw: assert property (@(posedge clk_sys) disable iff (rst) dipsw == dip_model)
        else abort_run($sformatf("Fail dipsw: expected %h, actual %h",
            $sampled(dip_model), $sampled(dipsw)));
    a_hs: assert property (@(posedge clk_sys) disable iff (rst) hs_resync == hs_expect)
        else abort_run($sformatf("Fail hs_resync: expected %b, actual %b",
            $sampled(hs_expect), $sampled(hs_resync)));
    a_vs: assert property (@(posedge clk_sys) disable iff (rst) vs_resync == vs_expect)
        else abort_run($sformatf("Fail vs_resync: expected %b, actual %b",
            $sampled(vs_expect), $sampled(vs_resync)));

    initial begin : main_flow
        logic [31:0] r;
        rst = 1'b1;
        hps_download = 1'b0;
        hps_index = mister_pkg::ROM_INDEX;
        hps_wr = 1'b0;
        hps_addr = '0;
        hps_dout = '0;
        prog_rdy = 1'b0;
        status = 32'h2500_0000;
        pxl_cen = 1'b0;
        hs = 1'b0;
        vs = 1'b0;
        quiet_phase = 1'b0;
        rand_state = 32'h0289_2a58;
        repeat (10) @(posedge clk_sys);
        #1;
        rst = 1'b0;
        repeat (4) next_cycle();

        // ROM download, consecutive byte addresses
        hps_download = 1'b1;
        for (int i = 0; i < ROM_BYTES; i++) begin
            r = lcg_next();
            send_rom_byte(AW'(i), r[23:16]);
        end
        next_cycle();
        hps_download = 1'b0;
        repeat (4) next_cycle();

        // DIP bytes out of address order, then an index that is ignored
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            dip_bytes[i] = r[15:8];
        end
        quiet_phase = 1'b1;
        hps_index = mister_pkg::DIP_INDEX;
        hps_download = 1'b1;
        write_strobe(AW'(3), dip_bytes[3]);
        write_strobe(AW'(1), dip_bytes[1]);
        write_strobe(AW'(0), dip_bytes[0]);
        write_strobe(AW'(2), dip_bytes[2]);
        hps_download = 1'b0;
        next_cycle();
        hps_index = 8'd5;
        hps_download = 1'b1;
        write_strobe(AW'(0), 8'hff);
        write_strobe(AW'(2), 8'h5a);
        hps_download = 1'b0;
        next_cycle();
        quiet_phase = 1'b0;
        hps_index = mister_pkg::ROM_INDEX;

        // Second offset pair
        repeat (2 * FRAME_CYCLES) next_cycle();
        status = 32'h7000_0000;
        repeat (3 * FRAME_CYCLES) next_cycle();

        assert (sent_count == ROM_BYTES)
            else abort_run($sformatf("Fail rom_accepted: expected %0d, actual %0d",
                ROM_BYTES, sent_count));
        assert (rise_count == sent_count)
            else abort_run($sformatf("Fail rom_writes: expected %0d, actual %0d",
                sent_count, rise_count));
        assert (dipsw == {dip_bytes[3], dip_bytes[2], dip_bytes[1], dip_bytes[0]})
            else abort_run($sformatf("Fail dip_final: expected %h, actual %h",
                {dip_bytes[3], dip_bytes[2], dip_bytes[1], dip_bytes[0]}, dipsw));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
mister_pkg.sv
dwnld_if.sv
dwnld_router.sv
prog_writer.sv
sync_resync.sv
mister_top.sv
tb_mister_top.sv
